//--- vlog.f
verilog/emesh_pkg.sv
verilog/emesh_if.sv
verilog/emesh_traffic_gen.sv
verilog/emesh2packet.sv
verilog/packet2emesh.sv
verilog/emesh_mem_target.sv
verilog/emesh_loopback_top.sv
testbench/tb_clock_gen.sv
testbench/tb_emesh_loopback.sv

//--- Bender.yml
package:
  name: emesh_loopback

sources:
  - verilog/emesh_pkg.sv
  - verilog/emesh_if.sv
  - verilog/emesh_traffic_gen.sv
  - verilog/emesh2packet.sv
  - verilog/packet2emesh.sv
  - verilog/emesh_mem_target.sv
  - verilog/emesh_loopback_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_emesh_loopback.sv

//--- testbench/tb_emesh_loopback.sv
`default_nettype none

module tb_emesh_loopback;
   timeunit 1ns;
   timeprecision 1ps;
   import emesh_pkg::*;

   localparam logic [11:0] gen_src_id = 12'h810;   // ids set in the top level
   localparam logic [11:0] gen_dst_id = 12'h820;
   localparam int unsigned wait_limit = 400;       // cycles per wait loop

   typedef struct packed {
      logic [addr_width-1:0] dstaddr;
      logic [addr_width-1:0] srcaddr;
      logic [data_width-1:0] data;
   } txn_t;

   logic                  clk;
   logic                  reset;
   logic                  start;
   logic                  write_mode;
   logic                  rsp_wait;
   logic                  done;
   logic                  req_access;
   logic                  rsp_access;
   logic [addr_width-1:0] rsp_dstaddr;
   logic [addr_width-1:0] rsp_srcaddr;
   logic [data_width-1:0] rsp_data;

   // memory model, indexed like the target
   logic [data_width-1:0] shadow [mem_depth];
   int unsigned write_count;    // writes seen this burst
   int unsigned read_count;     // reads seen this burst
   int unsigned rsp_count;      // responses seen this burst
   int unsigned held_cycles;    // cycles a response sat under rsp_wait
   logic        burst_is_read;
   logic        stall_enable;
   logic        prev_req_access;
   logic        prev_rsp_access;
   logic        prev_rsp_wait;
   logic        rise;
   txn_t        exp_rsp;
   txn_t        held_rsp;

   tb_clock_gen clk_gen_i (
      .clk   (clk),
      .reset (reset)
   );

   emesh_loopback_top dut_i (
      .clk         (clk),
      .reset       (reset),
      .start       (start),
      .write_mode  (write_mode),
      .rsp_wait    (rsp_wait),
      .done        (done),
      .req_access  (req_access),
      .rsp_access  (rsp_access),
      .rsp_dstaddr (rsp_dstaddr),
      .rsp_srcaddr (rsp_srcaddr),
      .rsp_data    (rsp_data)
   );

   task automatic show_mismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
      $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic halt_with_message(input string what);
      $display("Error at %0t ns: %s", $time, what);
      $display(">>> FAIL");
      $fatal(1, "stopped at first error");
   endtask

   function automatic logic [mem_index_width-1:0] word_index(input logic [addr_width-1:0] addr);
      return addr[mem_index_lsb +: mem_index_width];
   endfunction

   // generator fields of the index-th transaction
   // fields step on the same edge as access rises, so index 0 is already one step in
   function automatic txn_t gen_txn(input int unsigned index);
      txn_t t;
      t.dstaddr = {gen_dst_id, 20'h0_0000};
      t.srcaddr = {gen_src_id, 20'h0_0000};
      t.data    = '0;
      for (int unsigned i = 0; i <= index; i++)
      begin
         t.dstaddr = (t.dstaddr + 32'd4) & addr_step_mask;   // one word
         t.srcaddr = (t.srcaddr + 32'd4) & addr_step_mask;
         t.data    = (t.data + 32'd1) & addr_step_mask;
      end
      return t;
   endfunction

   // write-back response for the index-th read
   function automatic txn_t expected_rsp(input int unsigned index);
      txn_t g;
      txn_t r;
      g = gen_txn(index);
      r.dstaddr = g.srcaddr;   // back to the requester
      r.srcaddr = g.dstaddr;   // address that was read
      r.data    = shadow[word_index(g.dstaddr)];
      return r;
   endfunction

   // random stalls on the response side
   initial
   begin
      void'($urandom(32'ha380_44b5));
      rsp_wait <= 1'b0;
      forever
      begin
         @(posedge clk);
         rsp_wait <= stall_enable && ($urandom % 2 == 1);
      end
   end

   // compares every cycle, sampled mid-cycle where all is settled
   always @(negedge clk)
   begin
      if (reset)
      begin
         prev_req_access = 1'b0;
         prev_rsp_access = 1'b0;
         prev_rsp_wait   = 1'b0;
      end
      else
      begin
         rise = rsp_access && !prev_rsp_access;
         if (prev_rsp_wait)
            assert (!req_access)
            else halt_with_message("req_access high in the cycle after rsp_wait was high");
         if (!burst_is_read)
            assert (!rsp_access) else halt_with_message("rsp_access seen during a write burst");
         if (req_access && burst_is_read)
            read_count++;
         else if (req_access)
         begin
            exp_rsp = gen_txn(write_count);   // store into the model
            shadow[word_index(exp_rsp.dstaddr)] = exp_rsp.data;
            write_count++;
         end
         if (rise)
            assert (prev_req_access)
            else halt_with_message("rsp_access rose without a read one cycle before");
         if (prev_req_access && burst_is_read)
            assert (rise) else halt_with_message("no response one cycle after a read");
         if (rise)
         begin
            assert (rsp_count < gen_count)
            else halt_with_message("more responses than reads in the burst");
            exp_rsp = expected_rsp(rsp_count);
            assert (rsp_dstaddr === exp_rsp.dstaddr)
            else show_mismatch("rsp_dstaddr", exp_rsp.dstaddr, rsp_dstaddr);
            assert (rsp_srcaddr === exp_rsp.srcaddr)
            else show_mismatch("rsp_srcaddr", exp_rsp.srcaddr, rsp_srcaddr);
            assert (rsp_data === exp_rsp.data)
            else show_mismatch("rsp_data", exp_rsp.data, rsp_data);
            held_rsp = exp_rsp;
            rsp_count++;
         end
         else if (rsp_access)
         begin
            held_cycles++;   // stalled beat must not move
            assert (rsp_dstaddr === held_rsp.dstaddr)
            else show_mismatch("rsp_dstaddr", held_rsp.dstaddr, rsp_dstaddr);
            assert (rsp_srcaddr === held_rsp.srcaddr)
            else show_mismatch("rsp_srcaddr", held_rsp.srcaddr, rsp_srcaddr);
            assert (rsp_data === held_rsp.data)
            else show_mismatch("rsp_data", held_rsp.data, rsp_data);
         end
         prev_req_access = req_access;
         prev_rsp_access = rsp_access;
         prev_rsp_wait   = rsp_wait;
      end
   end

   task automatic wait_for_reset();
      int unsigned cycles;
      cycles = 0;
      do
      begin
         @(posedge clk);
         cycles++;
         if (cycles > wait_limit)
            halt_with_message("reset was never released");
      end
      while (reset);
   endtask

   // one start pulse, then wait for done and the responses
   task automatic run_burst(input logic write_burst, input logic with_stalls);
      int unsigned cycles;
      int unsigned expected_rsps;
      expected_rsps = write_burst ? 0 : gen_count;
      @(posedge clk);
      burst_is_read = !write_burst;
      write_count   = 0;
      read_count    = 0;
      rsp_count     = 0;
      write_mode <= write_burst;
      start      <= 1'b1;
      @(posedge clk);
      start <= 1'b0;   // accepted on this edge
      @(negedge clk);
      assert (!done) else show_mismatch("done", 32'd0, done);
      stall_enable = with_stalls;
      cycles = 0;
      while (!done)
      begin
         @(negedge clk);
         cycles++;
         if (cycles > wait_limit)
            halt_with_message("burst never reached done");
      end
      stall_enable = 1'b0;
      cycles = 0;
      do
      begin
         @(posedge clk);
         cycles++;
         if (cycles > wait_limit)
            halt_with_message("responses still missing long after done");
      end
      while (rsp_count < expected_rsps);
      repeat (4) @(negedge clk);   // nothing else may show up
      assert (done) else show_mismatch("done", 32'd1, done);
      @(posedge clk);
      assert (rsp_count == expected_rsps)
      else show_mismatch("response count", expected_rsps, rsp_count);
      if (write_burst)
         assert (write_count == gen_count)
         else show_mismatch("write count", gen_count, write_count);
      else
         assert (read_count == gen_count)
         else show_mismatch("read count", gen_count, read_count);
   endtask

   initial
   begin
      write_count   = 0;
      read_count    = 0;
      rsp_count     = 0;
      held_cycles   = 0;
      burst_is_read = 1'b0;
      stall_enable  = 1'b0;
      start      <= 1'b0;
      write_mode <= 1'b0;
      wait_for_reset();
      @(negedge clk);
      assert (done === 1'b0) else show_mismatch("done", 32'd0, done);
      assert (req_access === 1'b0) else show_mismatch("req_access", 32'd0, req_access);
      assert (rsp_access === 1'b0) else show_mismatch("rsp_access", 32'd0, rsp_access);
      run_burst(1'b1, 1'b0);   // fill memory
      run_burst(1'b0, 1'b0);   // plain read back
      run_burst(1'b0, 1'b1);   // read back under stalls
      assert (held_cycles > 0)
      else halt_with_message("random stalls never held a response on the outputs");
      run_burst(1'b0, 1'b0);   // restart from done, same answers
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`default_nettype none

// free running clock plus power-on reset
module tb_clock_gen (
   output logic clk,
   output logic reset
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned reset_cycles = 4;

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // 100 ns period
   end

   initial
   begin
      reset = 1'b1;
      repeat (reset_cycles) @(posedge clk);
      reset <= 1'b0;   // released on a rising edge
   end

endmodule

`default_nettype wire

//--- verilog/emesh_loopback_top.sv
`default_nettype none

module emesh_loopback_top (
   input  wire logic                          clk,
   input  wire logic                          reset,
   input  wire logic                          start,
   input  wire logic                          write_mode,
   input  wire logic                          rsp_wait,
   output logic                               done,
   output logic                               req_access,   // generator pulse
   output logic                               rsp_access,
   output logic [emesh_pkg::addr_width-1:0]   rsp_dstaddr,
   output logic [emesh_pkg::addr_width-1:0]   rsp_srcaddr,
   output logic [emesh_pkg::data_width-1:0]   rsp_data
);
   import emesh_pkg::*;

   // serialized link between packer and unpacker
   logic                    link_access;
   logic [packet_width-1:0] link_packet;
   logic                    link_wait;

   emesh_if gen_bus ();   // generator side
   emesh_if req_bus ();   // target side

   // sender core 0x810 addressing core 0x820
   emesh_traffic_gen #(
      .src_id (12'h810),
      .dst_id (12'h820)
   ) gen_i (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .write_mode (write_mode),
      .done       (done),
      .bus        (gen_bus.src)
   );

   emesh2packet e2p_i (
      .bus     (gen_bus.dst),
      .packet  (link_packet),
      .access  (link_access),
      .wait_in (link_wait)
   );

   packet2emesh p2e_i (
      .access    (link_access),
      .packet    (link_packet),
      .link_wait (link_wait),
      .bus       (req_bus.src)
   );

   emesh_mem_target mem_i (
      .clk         (clk),
      .reset       (reset),
      .req         (req_bus.dst),
      .rsp_wait    (rsp_wait),
      .rsp_access  (rsp_access),
      .rsp_dstaddr (rsp_dstaddr),
      .rsp_srcaddr (rsp_srcaddr),
      .rsp_data    (rsp_data)
   );

   assign req_access = gen_bus.access;   // for latency checks

endmodule

`default_nettype wire

//--- verilog/emesh_mem_target.sv
`default_nettype none

module emesh_mem_target (
   input  wire logic                              clk,
   input  wire logic                              reset,
   emesh_if.dst                                   req,
   input  wire logic                              rsp_wait,
   output logic                                   rsp_access,
   output logic [emesh_pkg::addr_width-1:0]       rsp_dstaddr,
   output logic [emesh_pkg::addr_width-1:0]       rsp_srcaddr,
   output logic [emesh_pkg::data_width-1:0]       rsp_data
);
   import emesh_pkg::*;

   logic [data_width-1:0]      mem [mem_depth];
   logic [mem_index_width-1:0] index;
   logic                       word_req;   // valid 32-bit access this cycle
   logic                       wr_req;
   logic                       rd_req;

   assign index    = req.dstaddr[mem_index_lsb +: mem_index_width];
   assign word_req = req.access && (req.datamode == word_datamode);
   assign wr_req   = word_req && req.write;
   assign rd_req   = word_req && !req.write;

   // wait while the response side is stalled.
   // a read in flight also raises it for one cycle, so the next read
   // cannot land on a response that rsp_wait is still holding
   assign req.stall = rsp_wait || rd_req;

   // word store
   always_ff @(posedge clk)
   begin
      if (wr_req)
         mem[index] <= req.data;
   end

   // response valid, held until taken
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         rsp_access <= 1'b0;
      else if (rd_req)
         rsp_access <= 1'b1;   // one cycle after the read
      else if (!rsp_wait)
         rsp_access <= 1'b0;   // taken this cycle, drop it
   end

   // response fields, a write-back to the requester
   always_ff @(posedge clk)
   begin
      if (rd_req)
      begin
         rsp_dstaddr <= req.srcaddr;   // back to whoever asked
         rsp_srcaddr <= req.dstaddr;   // address that was read
         rsp_data    <= mem[index];
      end
   end

   // a held response is never overwritten by a new read
   a_no_read_over_held_rsp : assert property (
      @(posedge clk) disable iff (reset)
      rd_req |-> !(rsp_access && rsp_wait)
   ) else $error("read arrived while a stalled response was still pending");

endmodule

`default_nettype wire

//--- verilog/packet2emesh.sv
`default_nettype none

module packet2emesh (
   input  wire logic                             access,
   input  wire logic [emesh_pkg::packet_width-1:0] packet,
   output logic                                  link_wait,
   emesh_if.src                                  bus
);
   import emesh_pkg::*;

   // pull every field out of its slot
   assign bus.access   = access;
   assign bus.write    = packet[pkt_write_bit];
   assign bus.datamode = packet[pkt_datamode_lsb +: 2];
   assign bus.ctrlmode = packet[pkt_ctrlmode_lsb +: 4];
   assign bus.dstaddr  = packet[pkt_dstaddr_lsb +: addr_width];
   assign bus.data     = packet[pkt_data_lsb +: data_width];
   assign bus.srcaddr  = packet[pkt_srcaddr_lsb +: addr_width];
   // reserved bit 7 is not looked at

   // sink wait heads back over the link
   assign link_wait = bus.stall;

endmodule

`default_nettype wire

//--- verilog/emesh2packet.sv
`default_nettype none

module emesh2packet (
   emesh_if.dst                                  bus,
   output logic [emesh_pkg::packet_width-1:0]    packet,
   output logic                                  access,
   input  wire logic                             wait_in    // from the link
);
   import emesh_pkg::*;

   // flatten the transaction into the packet
   always_comb
   begin
      packet = '0;   // reserved bit 7 stays zero
      packet[pkt_write_bit]                   = bus.write;
      packet[pkt_datamode_lsb +: 2]           = bus.datamode;
      packet[pkt_ctrlmode_lsb +: 4]           = bus.ctrlmode;
      packet[pkt_dstaddr_lsb +: addr_width]   = bus.dstaddr;
      packet[pkt_data_lsb +: data_width]      = bus.data;
      packet[pkt_srcaddr_lsb +: addr_width]   = bus.srcaddr;
   end

   assign access    = bus.access;   // pulse passes straight through
   assign bus.stall = wait_in;      // link wait back to the source

endmodule

`default_nettype wire

//--- verilog/emesh_traffic_gen.sv
`default_nettype none

module emesh_traffic_gen #(
   parameter logic [11:0] src_id = 12'h000,   // core id of the sender
   parameter logic [11:0] dst_id = 12'h000    // core id being targeted
) (
   input  wire logic clk,
   input  wire logic reset,
   input  wire logic start,        // level, sampled in idle or done
   input  wire logic write_mode,   // 1 = write burst, 0 = read burst
   output logic      done,
   emesh_if.src      bus
);
   import emesh_pkg::*;

   logic [1:0]                 state;
   logic [gen_count_width-1:0] remaining;   // transactions left in burst
   logic                       access_reg;
   logic                       write_reg;
   logic [addr_width-1:0]      dstaddr_reg;
   logic [addr_width-1:0]      srcaddr_reg;
   logic [data_width-1:0]      data_reg;
   logic                       launch;      // start accepted this cycle
   logic                       issue;       // a transaction goes out next edge
   logic                       is_go;

   assign is_go  = (state == gen_go);
   assign done   = (state == gen_done);
   assign launch = start && (state == gen_idle || done);
   assign issue  = is_go && !bus.stall;    // wait seen low this cycle

   // burst fsm
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         state <= gen_idle;
      else if (launch)
         state <= gen_go;
      else if (issue && remaining == gen_count_width'(1))
         state <= gen_done;   // last one leaves on this edge
   end

   // access pulse and burst counter
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         access_reg <= 1'b0;
         remaining  <= gen_count_width'(gen_count);
      end
      else
      begin
         access_reg <= issue;   // low whenever wait was high
         if (launch)
            remaining <= gen_count_width'(gen_count);
         else if (issue)
            remaining <= remaining - 1'b1;
      end
   end

   // transaction fields, restart from the id window on every start
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         write_reg   <= 1'b0;
         dstaddr_reg <= {dst_id, 20'h0_0000};
         srcaddr_reg <= {src_id, 20'h0_0000};
         data_reg    <= '0;
      end
      else if (launch)
      begin
         write_reg   <= write_mode;   // held for the whole burst
         dstaddr_reg <= {dst_id, 20'h0_0000};
         srcaddr_reg <= {src_id, 20'h0_0000};
         data_reg    <= '0;
      end
      else if (issue)
      begin
         // step by one word, same edge as access rises
         dstaddr_reg <= (dstaddr_reg + (32'd1 << word_datamode)) & addr_step_mask;
         srcaddr_reg <= (srcaddr_reg + (32'd1 << word_datamode)) & addr_step_mask;
         data_reg    <= (data_reg + 32'd1) & addr_step_mask;
      end
   end

   assign bus.access   = access_reg;
   assign bus.write    = write_reg;
   assign bus.datamode = word_datamode;   // word accesses only
   assign bus.ctrlmode = 4'b0000;         // no special transactions
   assign bus.dstaddr  = dstaddr_reg;
   assign bus.srcaddr  = srcaddr_reg;
   assign bus.data     = data_reg;

   // the combinational wait path must reach the access register in time
   a_no_access_after_wait : assert property (
      @(posedge clk) disable iff (reset)
      bus.stall |=> !bus.access
   ) else $error("generator issued access in the cycle after wait");

endmodule

`default_nettype wire

//--- verilog/emesh_if.sv
`default_nettype none

// one decoded emesh transaction plus the wait level coming back
interface emesh_if;
   import emesh_pkg::*;

   logic                  access;    // one cycle pulse per transaction
   logic                  write;
   logic [1:0]            datamode;
   logic [3:0]            ctrlmode;
   logic [addr_width-1:0] dstaddr;
   logic [data_width-1:0] data;
   logic [addr_width-1:0] srcaddr;
   logic                  stall;     // emesh wait, sink to source

   // transaction source
   modport src (
      output access, write, datamode, ctrlmode,
      output dstaddr, data, srcaddr,
      input  stall
   );

   // transaction sink, owns the wait
   modport dst (
      input  access, write, datamode, ctrlmode,
      input  dstaddr, data, srcaddr,
      output stall
   );

endinterface

`default_nettype wire

//--- verilog/emesh_pkg.sv
`default_nettype none

package emesh_pkg;

   // bus widths
   localparam int unsigned packet_width = 104;  // full emesh packet
   localparam int unsigned addr_width   = 32;
   localparam int unsigned data_width   = 32;

   // packet layout, lsb of each field
   localparam int unsigned pkt_write_bit    = 0;   // 1 = write
   localparam int unsigned pkt_datamode_lsb = 1;   // bits 2..1
   localparam int unsigned pkt_ctrlmode_lsb = 3;   // bits 6..3
   // bit 7 reserved, sent as zero
   localparam int unsigned pkt_dstaddr_lsb  = 8;   // bits 39..8
   localparam int unsigned pkt_data_lsb     = 40;  // bits 71..40
   localparam int unsigned pkt_srcaddr_lsb  = 72;  // bits 103..72

   // keeps a stepping address inside the core's local window
   localparam logic [addr_width-1:0] addr_step_mask = 32'hFFF0_7FFF;

   // burst length and remaining-count width
   localparam int unsigned gen_count       = 16;
   localparam int unsigned gen_count_width = $clog2(gen_count + 1);

   // datamode 2 = 32-bit word
   localparam logic [1:0] word_datamode = 2'd2;

   // generator fsm encodings
   localparam logic [1:0] gen_idle = 2'd0;
   localparam logic [1:0] gen_go   = 2'd1;
   localparam logic [1:0] gen_done = 2'd2;

   // target memory, indexed by dstaddr[7:2]
   localparam int unsigned mem_depth       = 64;
   localparam int unsigned mem_index_width = $clog2(mem_depth);
   localparam int unsigned mem_index_lsb   = 2;   // word aligned

endpackage

`default_nettype wire
